// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module decodeTb \
	-f vlog.f -Mdir obj_dir -o decodeTbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/decodeTbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	exit 0
fi
exit 1

// ==== sim/decodeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeTb import mipsPkg::*; ();

	logic     clk;
	logic     arstN;
	logic     inReq;
	logic     inAck;
	wordT     pc;
	wordT     instr;
	logic     wbEn;
	regIdxT   wbReg;
	wordT     wbData;
	decodedT  outDecoded;
	redirectT outRedirect;

	// Expected register contents with r0 held at zero
	wordT shadowRegs [0:31];

	// Legal ALU function codes and immediate opcodes
	functT  rFns [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL};
	opcodeT iOps [8] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};

	decodeStage dut_i (
		.clk(clk), .arstN(arstN), .inReq(inReq), .inAck(inAck),
		.pc(pc), .instr(instr),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.outDecoded(outDecoded), .outRedirect(outRedirect)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		abortRun("Decode output differs from the reference model");
	endtask

	task automatic checkDecoded(input decodedT got, input decodedT exp);
		if (got.cls !== exp.cls) reportMismatch("cls", 32'(got.cls), 32'(exp.cls));
		if (got.aluOp !== exp.aluOp) reportMismatch("aluOp", 32'(got.aluOp), 32'(exp.aluOp));
		if (got.rsVal !== exp.rsVal) reportMismatch("rsVal", got.rsVal, exp.rsVal);
		if (got.rtVal !== exp.rtVal) reportMismatch("rtVal", got.rtVal, exp.rtVal);
		if (got.imm !== exp.imm) reportMismatch("imm", got.imm, exp.imm);
		if (got.shamt !== exp.shamt) reportMismatch("shamt", 32'(got.shamt), 32'(exp.shamt));
		if (got.writeEn !== exp.writeEn)
			reportMismatch("writeEn", 32'(got.writeEn), 32'(exp.writeEn));
		if (got.writeReg !== exp.writeReg)
			reportMismatch("writeReg", 32'(got.writeReg), 32'(exp.writeReg));
		if (got.memRead !== exp.memRead)
			reportMismatch("memRead", 32'(got.memRead), 32'(exp.memRead));
		if (got.memWrite !== exp.memWrite)
			reportMismatch("memWrite", 32'(got.memWrite), 32'(exp.memWrite));
		if (got.useImm !== exp.useImm)
			reportMismatch("useImm", 32'(got.useImm), 32'(exp.useImm));
		if (got.illegal !== exp.illegal)
			reportMismatch("illegal", 32'(got.illegal), 32'(exp.illegal));
	endtask

	task automatic checkRedirect(input redirectT got, input redirectT exp);
		if (got.taken !== exp.taken) reportMismatch("taken", 32'(got.taken), 32'(exp.taken));
		if (got.target !== exp.target) reportMismatch("target", got.target, exp.target);
	endtask

	// Class per the supported instruction list
	function automatic instrClassT classOf(input wordT ins);
		instrClassT c;
		opcodeT     op;
		functT      fn;
		op = ins[31:26];
		fn = ins[5:0];
		c = clsIllegal;
		if (op == OP_SPECIAL) begin
			if (fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT}) c = clsAluReg;
			if (fn inside {FN_SLL, FN_SRL}) c = clsShift;
			if (fn == FN_JR) c = clsJumpReg;
			if (fn == FN_JALR) c = clsJumpRegLink;
		end else begin
			case (op)
				OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: c = clsAluImm;
				OP_LUI:         c = clsLui;
				OP_LW:          c = clsLoad;
				OP_SW:          c = clsStore;
				OP_BEQ, OP_BNE: c = clsBranch;
				OP_J:           c = clsJump;
				OP_JAL:         c = clsJumpLink;
				default:        c = clsIllegal;
			endcase
		end
		return c;
	endfunction

	function automatic aluOpT functOp(input functT fn);
		case (fn)
			FN_SUBU: return aluSub;
			FN_AND:  return aluAnd;
			FN_OR:   return aluOr;
			FN_XOR:  return aluXor;
			FN_SLT:  return aluSlt;
			FN_SLL:  return aluSll;
			FN_SRL:  return aluSrl;
			default: return aluAdd;
		endcase
	endfunction

	function automatic aluOpT opcodeOp(input opcodeT op);
		case (op)
			OP_SLTI: return aluSlt;
			OP_ANDI: return aluAnd;
			OP_ORI:  return aluOr;
			OP_XORI: return aluXor;
			default: return aluAdd;
		endcase
	endfunction

	// Reference decode bundle
	function automatic decodedT expectDecoded(input wordT pcIn, input wordT ins);
		decodedT    d;
		instrClassT c;
		opcodeT     op;
		op = ins[31:26];
		c = classOf(ins);
		d = '0;
		d.cls = c;
		d.rsVal = shadowRegs[ins[25:21]];
		d.rtVal = shadowRegs[ins[20:16]];
		d.shamt = ins[10:6];
		case (c)
			clsAluReg, clsShift: d.aluOp = functOp(ins[5:0]);
			clsAluImm: d.aluOp = opcodeOp(op);
			clsLui, clsJumpLink, clsJumpRegLink: d.aluOp = aluPassImm;
			clsBranch: d.aluOp = aluSub;
			default: d.aluOp = aluAdd;
		endcase
		// Link value, lui shift, logical zero extension, else sign extension
		if (c == clsJumpLink || c == clsJumpRegLink) d.imm = pcIn + 32'd8;
		else if (c == clsLui) d.imm = {ins[15:0], 16'h0000};
		else if (op inside {OP_ANDI, OP_ORI, OP_XORI}) d.imm = {16'h0000, ins[15:0]};
		else d.imm = {{16{ins[15]}}, ins[15:0]};
		case (c)
			clsAluReg, clsShift, clsJumpRegLink: d.writeReg = ins[15:11];
			clsAluImm, clsLui, clsLoad: d.writeReg = ins[20:16];
			clsJumpLink: d.writeReg = LINK_REG;
			default: d.writeReg = '0;
		endcase
		d.writeEn = c inside {clsAluReg, clsShift, clsAluImm, clsLui, clsLoad,
			clsJumpLink, clsJumpRegLink};
		d.memRead = (c == clsLoad);
		d.memWrite = (c == clsStore);
		d.useImm = c inside {clsAluImm, clsLui, clsLoad, clsStore};
		d.illegal = (c == clsIllegal);
		return d;
	endfunction

	// Reference redirect bundle
	function automatic redirectT expectRedirect(input wordT pcIn, input wordT ins);
		redirectT r;
		wordT     pc4;
		wordT     rsv;
		wordT     rtv;
		pc4 = pcIn + 32'd4;
		rsv = shadowRegs[ins[25:21]];
		rtv = shadowRegs[ins[20:16]];
		r = '0;
		case (classOf(ins))
			clsBranch: begin
				// Not-taken branch still reports its target
				r.target = pc4 + ({{16{ins[15]}}, ins[15:0]} << 2);
				r.taken = (ins[31:26] == OP_BEQ) ? (rsv == rtv) : (rsv != rtv);
			end
			clsJump, clsJumpLink: begin
				r.taken = 1'b1;
				r.target = {pc4[31:28], ins[25:0], 2'b00};
			end
			clsJumpReg, clsJumpRegLink: begin
				r.taken = 1'b1;
				r.target = rsv;
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic wordT rType(input regIdxT rs, input regIdxT rt, input regIdxT rd,
		input logic [4:0] sh, input functT fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic wordT iType(input opcodeT op, input regIdxT rs, input regIdxT rt,
		input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic regIdxT randReg();
		return regIdxT'($urandom);
	endfunction

	// Word aligned fetch address
	function automatic wordT randPc();
		return wordT'($urandom) & 32'hFFFF_FFFC;
	endfunction

	// Inputs move 2 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	// Only while inReq and inAck are low
	task automatic writeOne(input regIdxT r, input wordT data);
		wbEn = 1'b1;
		wbReg = r;
		wbData = data;
		if (r != '0) shadowRegs[r] = data;
		nextCycle();
		wbEn = 1'b0;
	endtask

	task automatic writeBurst(input int count);
		// r0 write must be dropped
		writeOne('0, wordT'($urandom));
		repeat (count) writeOne(randReg(), wordT'($urandom));
	endtask

	// One four-phase transfer with protocol and bundle checks
	task automatic runInstr(input wordT pcIn, input wordT ins);
		decodedT  expD;
		redirectT expR;
		int       edges;
		expD = expectDecoded(pcIn, ins);
		expR = expectRedirect(pcIn, ins);
		pc = pcIn;
		instr = ins;
		inReq = 1'b1;
		edges = 0;
		while (!inAck) begin
			nextCycle();
			edges++;
			if (edges > 20) abortRun("Timeout: inAck never rose after inReq");
		end
		if (edges != 2) abortRun($sformatf("inAck rose after %0d edges instead of 2", edges));
		checkDecoded(outDecoded, expD);
		checkRedirect(outRedirect, expR);
		// Fetch stalls while outputs hold
		repeat ($urandom_range(0, 4)) begin
			nextCycle();
			if (!inAck) abortRun("inAck dropped while inReq was still high");
			checkDecoded(outDecoded, expD);
			checkRedirect(outRedirect, expR);
		end
		inReq = 1'b0;
		pc = randPc();
		instr = wordT'($urandom);
		edges = 0;
		while (inAck) begin
			nextCycle();
			edges++;
			if (edges > 20) abortRun("Timeout: inAck never fell after inReq dropped");
		end
		if (edges != 1) abortRun($sformatf("inAck fell after %0d edges instead of 1", edges));
	endtask

	initial begin
		regIdxT a;
		regIdxT b;
		wordT   v;
		opcodeT op;
		functT  fn;
		void'($urandom(64136));
		arstN = 1'b0;
		inReq = 1'b0;
		pc = '0;
		instr = '0;
		wbEn = 1'b0;
		wbReg = '0;
		wbData = '0;
		for (int i = 0; i < 32; i++) shadowRegs[i] = '0;
		repeat (4) @(posedge clk);
		#2;
		arstN = 1'b1;

		// Reset state
		if (inAck !== 1'b0) abortRun("inAck is not low after reset");
		checkDecoded(outDecoded, '0);
		checkRedirect(outRedirect, '0);
		runInstr(randPc(), rType(randReg(), randReg(), randReg(), 5'd0, FN_ADDU));

		// Writeback bursts then ALU ops
		repeat (8) begin
			writeBurst(6);
			// r0 read right after its write
			runInstr(randPc(), rType(5'd0, randReg(), randReg(), 5'd0, FN_ADDU));
			repeat (6) begin
				if ($urandom_range(0, 1) == 0)
					runInstr(randPc(), rType(randReg(), randReg(), randReg(),
						5'($urandom), rFns[3'($urandom)]));
				else
					runInstr(randPc(), iType(iOps[3'($urandom)], randReg(), randReg(),
						16'($urandom)));
			end
		end

		// Immediate forms
		repeat (24) runInstr(randPc(), iType(iOps[3'($urandom)], randReg(), randReg(),
			16'($urandom)));

		// Branches on equal and unequal pairs, then jumps
		repeat (6) begin
			a = regIdxT'($urandom_range(1, 31));
			b = (a == 5'd31) ? 5'd1 : a + 5'd1;
			v = wordT'($urandom);
			writeOne(a, v);
			writeOne(b, v);
			runInstr(randPc(), iType(OP_BEQ, a, b, 16'($urandom)));
			runInstr(randPc(), iType(OP_BNE, a, b, 16'($urandom)));
			writeOne(b, v ^ wordT'($urandom_range(1, 255)));
			runInstr(randPc(), iType(OP_BEQ, a, b, 16'($urandom)));
			runInstr(randPc(), iType(OP_BNE, a, b, 16'($urandom)));
			runInstr(randPc(), {OP_J, 26'($urandom)});
			runInstr(randPc(), {OP_JAL, 26'($urandom)});
			runInstr(randPc(), rType(randReg(), randReg(), randReg(), 5'd0, FN_JR));
			runInstr(randPc(), rType(randReg(), randReg(), randReg(), 5'd0, FN_JALR));
		end

		// Unknown opcodes and unknown function codes
		repeat (8) begin
			do begin
				op = opcodeT'($urandom);
			end while (op inside {OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU,
				OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW});
			runInstr(randPc(), {op, 26'($urandom)});
			do begin
				fn = functT'($urandom);
			end while (fn inside {FN_SLL, FN_SRL, FN_JR, FN_JALR, FN_ADDU, FN_SUBU,
				FN_AND, FN_OR, FN_XOR, FN_SLT});
			runInstr(randPc(), rType(randReg(), randReg(), randReg(), 5'($urandom), fn));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/aluDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecoder import mipsPkg::*; (
	input  instrClassT cls,
	input  opcodeT     opcode,
	input  functT      funct,
	output aluOpT      aluOp,
	output logic       useImm,
	output logic       zeroExt
);

	// ALU operation select
	always_comb begin
		aluOp = aluAdd;
		unique case (cls)
			clsAluReg, clsShift: begin
				// Function field picks the op
				unique case (funct)
					FN_SUBU: aluOp = aluSub;
					FN_AND:  aluOp = aluAnd;
					FN_OR:   aluOp = aluOr;
					FN_XOR:  aluOp = aluXor;
					FN_SLT:  aluOp = aluSlt;
					FN_SLL:  aluOp = aluSll;
					FN_SRL:  aluOp = aluSrl;
					default: aluOp = aluAdd;
				endcase
			end
			clsAluImm: begin
				// Opcode picks the op
				unique case (opcode)
					OP_SLTI: aluOp = aluSlt;
					OP_ANDI: aluOp = aluAnd;
					OP_ORI:  aluOp = aluOr;
					OP_XORI: aluOp = aluXor;
					default: aluOp = aluAdd;
				endcase
			end
			clsLui:                      aluOp = aluPassImm;
			// Link value travels in imm
			clsJumpLink, clsJumpRegLink: aluOp = aluPassImm;
			clsBranch:                   aluOp = aluSub;
			// Address add, plain jumps, illegal
			default:                     aluOp = aluAdd;
		endcase
	end

	// Second operand from the immediate
	assign useImm = (cls == clsAluImm) || (cls == clsLui) ||
		(cls == clsLoad) || (cls == clsStore);

	// Logical immediates are zero extended
	assign zeroExt = (cls == clsAluImm) &&
		((opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI));

endmodule

`default_nettype wire

// ==== src/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnit import mipsPkg::*; (
	input  instrClassT cls,
	input  opcodeT     opcode,
	input  wordT       pc,
	input  wordT       instr,
	input  wordT       rsVal,
	input  wordT       rtVal,
	output redirectT   redirect
);

	wordT pcPlus4;
	wordT branchTarget;
	wordT jumpTarget;
	logic regsEqual;

	// Sequential address
	assign pcPlus4 = pc + 32'd4;

	// Word offset relative to the delay slot address
	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};

	// Region of pc+4 with the 26-bit index
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	assign regsEqual = (rsVal == rtVal);

	// Select target and taken flag by class
	always_comb begin
		redirect = '0;
		unique case (cls)
			clsBranch: begin
				redirect.target = branchTarget;
				// beq on equal, bne on differ
				redirect.taken = ((opcode == OP_BEQ) && regsEqual) ||
					((opcode == OP_BNE) && !regsEqual);
			end
			clsJump, clsJumpLink: begin
				redirect.taken  = 1'b1;
				redirect.target = jumpTarget;
			end
			clsJumpReg, clsJumpRegLink: begin
				redirect.taken  = 1'b1;
				redirect.target = rsVal;
			end
			// No redirect for anything else
			default: redirect = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsPkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  logic     inReq,
	output logic     inAck,
	input  wordT     pc,
	input  wordT     instr,
	input  logic     wbEn,
	input  regIdxT   wbReg,
	input  wordT     wbData,
	output decodedT  outDecoded,
	output redirectT outRedirect
);

	hsStateT    state;
	// Captured fetch word
	wordT       pcQ;
	wordT       instrQ;
	// Decode results
	instrClassT cls;
	aluOpT      aluOp;
	wordT       rsVal;
	wordT       rtVal;
	wordT       imm;
	wordT       pcPlus8;
	logic       memRead;
	logic       memWrite;
	logic       writeEn;
	regIdxT     writeReg;
	logic       useImm;
	logic       zeroExt;
	decodedT    decodedNext;
	redirectT   redirectNext;

	// Read addresses from rs and rt
	regFile regFile_i (
		.clk(clk), .arstN(arstN),
		.rdAddrA(instrQ[25:21]), .rdAddrB(instrQ[20:16]),
		.rdDataA(rsVal), .rdDataB(rtVal),
		.wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData)
	);

	mainDecoder mainDecoder_i (
		.instr(instrQ), .cls(cls), .memRead(memRead), .memWrite(memWrite),
		.writeEn(writeEn), .writeReg(writeReg)
	);

	aluDecoder aluDecoder_i (
		.cls(cls), .opcode(instrQ[31:26]), .funct(instrQ[5:0]),
		.aluOp(aluOp), .useImm(useImm), .zeroExt(zeroExt)
	);

	branchUnit branchUnit_i (
		.cls(cls), .opcode(instrQ[31:26]), .pc(pcQ), .instr(instrQ),
		.rsVal(rsVal), .rtVal(rtVal), .redirect(redirectNext)
	);

	// Return address for jal and jalr
	assign pcPlus8 = pcQ + 32'd8;

	// Immediate formation
	always_comb begin
		if ((cls == clsJumpLink) || (cls == clsJumpRegLink)) begin
			imm = pcPlus8;
		end else if (cls == clsLui) begin
			imm = {instrQ[15:0], 16'h0000};
		end else if (zeroExt) begin
			imm = {16'h0000, instrQ[15:0]};
		end else begin
			imm = {{16{instrQ[15]}}, instrQ[15:0]};
		end
	end

	// Bundle assembly
	assign decodedNext = '{cls: cls, aluOp: aluOp, rsVal: rsVal, rtVal: rtVal,
		imm: imm, shamt: instrQ[10:6], writeEn: writeEn, writeReg: writeReg,
		memRead: memRead, memWrite: memWrite, useImm: useImm,
		illegal: (cls == clsIllegal)};

	// Capture registers only load in stIdle
	always_ff @(posedge clk) begin
		if ((state == stIdle) && inReq) begin
			pcQ    <= pc;
			instrQ <= instr;
		end
	end

	// Four-phase handshake with fetch
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state       <= stIdle;
			inAck       <= 1'b0;
			outDecoded  <= '0;
			outRedirect <= '0;
		end else begin
			unique case (state)
				stIdle: begin
					if (inReq) begin
						state <= stDecode;
					end
				end
				stDecode: begin
					// Bundles valid together with inAck
					outDecoded  <= decodedNext;
					outRedirect <= redirectNext;
					inAck       <= 1'b1;
					state       <= stAck;
				end
				stAck: begin
					// Hold outputs until fetch drops inReq
					if (!inReq) begin
						inAck <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDecoder import mipsPkg::*; (
	input  wordT       instr,
	output instrClassT cls,
	output logic       memRead,
	output logic       memWrite,
	output logic       writeEn,
	output regIdxT     writeReg
);

	// Instruction fields
	opcodeT opcode;
	functT  funct;
	regIdxT rt;
	regIdxT rd;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// Classify by opcode, then by function code for SPECIAL
	always_comb begin
		cls = clsIllegal;
		unique case (opcode)
			OP_SPECIAL: begin
				unique case (funct)
					FN_ADDU, FN_SUBU, FN_AND,
					FN_OR, FN_XOR, FN_SLT: cls = clsAluReg;
					FN_SLL, FN_SRL:        cls = clsShift;
					FN_JR:                 cls = clsJumpReg;
					FN_JALR:               cls = clsJumpRegLink;
					default:               cls = clsIllegal;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI,
			OP_ORI, OP_XORI: cls = clsAluImm;
			OP_LUI:          cls = clsLui;
			OP_LW:           cls = clsLoad;
			OP_SW:           cls = clsStore;
			OP_BEQ, OP_BNE:  cls = clsBranch;
			OP_J:            cls = clsJump;
			OP_JAL:          cls = clsJumpLink;
			default:         cls = clsIllegal;
		endcase
	end

	// Memory controls
	assign memRead  = (cls == clsLoad);
	assign memWrite = (cls == clsStore);

	// Destination register and its enable
	always_comb begin
		writeEn  = 1'b0;
		writeReg = '0;
		unique case (cls)
			clsAluReg, clsShift, clsJumpRegLink: begin
				// R-type writes rd
				writeEn  = 1'b1;
				writeReg = rd;
			end
			clsAluImm, clsLui, clsLoad: begin
				// I-type writes rt
				writeEn  = 1'b1;
				writeReg = rt;
			end
			clsJumpLink: begin
				writeEn  = 1'b1;
				writeReg = LINK_REG;
			end
			// Stores, branches, plain jumps, illegal
			default: begin
				writeEn  = 1'b0;
				writeReg = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// Width types
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIdxT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	// Instruction classes seen by the decoder
	typedef enum logic [3:0] {
		clsAluReg,
		clsShift,
		clsAluImm,
		clsLui,
		clsLoad,
		clsStore,
		clsBranch,
		clsJump,
		clsJumpLink,
		clsJumpReg,
		clsJumpRegLink,
		clsIllegal
	} instrClassT;

	// ALU operations handed to execute
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassImm
	} aluOpT;

	// Fetch handshake states
	typedef enum logic [1:0] {
		stIdle,
		stDecode,
		stAck
	} hsStateT;

	// Primary opcodes
	localparam opcodeT OP_SPECIAL = 6'h00;
	localparam opcodeT OP_J       = 6'h02;
	localparam opcodeT OP_JAL     = 6'h03;
	localparam opcodeT OP_BEQ     = 6'h04;
	localparam opcodeT OP_BNE     = 6'h05;
	localparam opcodeT OP_ADDIU   = 6'h09;
	localparam opcodeT OP_SLTI    = 6'h0A;
	localparam opcodeT OP_ANDI    = 6'h0C;
	localparam opcodeT OP_ORI     = 6'h0D;
	localparam opcodeT OP_XORI    = 6'h0E;
	localparam opcodeT OP_LUI     = 6'h0F;
	localparam opcodeT OP_LW      = 6'h23;
	localparam opcodeT OP_SW      = 6'h2B;

	// Function codes under OP_SPECIAL
	localparam functT FN_SLL  = 6'h00;
	localparam functT FN_SRL  = 6'h02;
	localparam functT FN_JR   = 6'h08;
	localparam functT FN_JALR = 6'h09;
	localparam functT FN_ADDU = 6'h21;
	localparam functT FN_SUBU = 6'h23;
	localparam functT FN_AND  = 6'h24;
	localparam functT FN_OR   = 6'h25;
	localparam functT FN_XOR  = 6'h26;
	localparam functT FN_SLT  = 6'h2A;

	// Return address register for jal
	localparam regIdxT LINK_REG = 5'd31;

	// Bundle for execute
	typedef struct packed {
		instrClassT cls;
		aluOpT      aluOp;
		wordT       rsVal;
		wordT       rtVal;
		wordT       imm;
		logic [4:0] shamt;
		logic       writeEn;
		regIdxT     writeReg;
		logic       memRead;
		logic       memWrite;
		logic       useImm;
		logic       illegal;
	} decodedT;

	// Bundle for fetch
	typedef struct packed {
		logic taken;
		wordT target;
	} redirectT;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  regIdxT rdAddrA,
	input  regIdxT rdAddrB,
	output wordT   rdDataA,
	output wordT   rdDataB,
	input  logic   wrEn,
	input  regIdxT wrAddr,
	input  wordT   wrData
);

	// Register 0 has no storage
	wordT regs [1:31];

	// Write port
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			// Whole file starts at zero
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			// Writes to r0 dropped
			regs[wrAddr] <= wrData;
		end
	end

	// Read port A
	always_comb begin
		if (rdAddrA == '0) begin
			rdDataA = '0;
		end else begin
			rdDataA = regs[rdAddrA];
		end
	end

	// Read port B
	always_comb begin
		if (rdAddrB == '0) begin
			rdDataB = '0;
		end else begin
			rdDataB = regs[rdAddrB];
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/mipsPkg.sv
src/regFile.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/branchUnit.sv
src/decodeStage.sv
sim/decodeTb.sv
